// ==== source/dcache_macros.svh ====
/*
 * data cache geometry and bus constants
 * two-way, 16 sets, 16-byte lines, 32-bit physical address
 */
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

`define DCACHE_WAY_NUM     2
`define DCACHE_IDX_WIDTH   4
`define DCACHE_BLOCK_SIZE  16
`define DCACHE_WORDS       (`DCACHE_BLOCK_SIZE / 4)
`define DCACHE_ADDR_WIDTH  32
`define DCACHE_OFS_WIDTH   4
`define DCACHE_TAG_WIDTH   (`DCACHE_ADDR_WIDTH - `DCACHE_IDX_WIDTH - `DCACHE_OFS_WIDTH)

// burst length field counts beats minus one
`define DCACHE_BURST_LEN   (`DCACHE_WORDS - 1)

// address slices
`define DCACHE_TAG_OF(a)   a[`DCACHE_ADDR_WIDTH-1 -: `DCACHE_TAG_WIDTH]
`define DCACHE_IDX_OF(a)   a[`DCACHE_OFS_WIDTH +: `DCACHE_IDX_WIDTH]
`define DCACHE_OFS_OF(a)   a[`DCACHE_OFS_WIDTH-1:0]
`define DCACHE_LINE_ALIGN(a) \
  {a[`DCACHE_ADDR_WIDTH-1:`DCACHE_OFS_WIDTH], {`DCACHE_OFS_WIDTH{1'b0}}}

`endif

// ==== source/dcache_pkg.sv ====
/*
 * data cache shared types
 * processor request and response, array payloads and bus channels
 */
`include "dcache_macros.svh"

package dcache_pkg;

  typedef enum logic {
    MEM_LOAD  = 1'b0,
    MEM_STORE = 1'b1
  } mem_op_e;

  typedef enum logic [2:0] {
    SIZE_B  = 3'd0,
    SIZE_H  = 3'd1,
    SIZE_W  = 3'd2,
    SIZE_BU = 3'd3,
    SIZE_HU = 3'd4
  } size_op_e;

  typedef logic [`DCACHE_ADDR_WIDTH-1:0] addr_t;
  typedef logic [`DCACHE_TAG_WIDTH-1:0]  tag_t;
  typedef logic [`DCACHE_IDX_WIDTH-1:0]  idx_t;
  typedef logic [`DCACHE_WORDS-1:0][31:0] line_t;

  typedef struct packed {
    logic        valid;
    addr_t       addr;
    mem_op_e     mem_op;
    size_op_e    size_op;
    logic [31:0] wdata;
  } dcache_req_t;

  typedef struct packed {
    logic        valid;
    mem_op_e     mem_op;
    logic [31:0] rdata;
  } dcache_rsp_t;

  typedef struct packed {
    logic valid;
    logic dirty;
  } meta_t;

  // pipe to miss engine
  typedef struct packed {
    addr_t line_addr;
    addr_t victim_addr;
    logic  victim_dirty;
    line_t victim_line;
  } miss_ctx_t;

  // ====================
  // bus channels
  // ====================
  typedef struct packed {
    logic       valid;
    addr_t      addr;
    logic [7:0] len;
  } axi_ax_t;

  typedef axi_ax_t axi_ar_t;
  typedef axi_ax_t axi_aw_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] data;
    logic        last;
  } axi_beat_t;

  typedef axi_beat_t axi_w_t;
  typedef axi_beat_t axi_r_t;

endpackage

// ==== source/dcache_sram.sv ====
`timescale 1ns/1ps

/*
 * simple dual-port array, one write and one registered read port
 * write-first when both ports hit the same entry
 */
module dcache_sram #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 16
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     we_i,
  input  logic [$clog2(DEPTH)-1:0] waddr_i,
  input  payload_t                 wdata_i,
  input  logic [$clog2(DEPTH)-1:0] raddr_i,
  output payload_t                 rdata_o
);

  payload_t mem [DEPTH];

  initial begin
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = '0;
    end
  end

  always @(posedge clk) begin
    if (we_i) begin
      mem[waddr_i] <= wdata_i;
    end
  end

  // bypass new data on a same-entry read
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdata_o <= '0;
    end else if (we_i && waddr_i == raddr_i) begin
      rdata_o <= wdata_i;
    end else begin
      rdata_o <= mem[raddr_i];
    end
  end

endmodule

// ==== source/dcache_byte_lane.sv ====
`timescale 1ns/1ps
`include "dcache_macros.svh"

/*
 * byte lane steering
 * store merge into a line copy, load extraction with sign or zero extension
 */
module dcache_byte_lane (
  input  dcache_pkg::size_op_e          size_i,
  input  logic [`DCACHE_OFS_WIDTH-1:0]  offset_i,
  input  dcache_pkg::line_t             line_i,
  input  logic [31:0]                   wdata_i,
  output dcache_pkg::line_t             store_line_o,
  output logic [31:0]                   load_data_o
);
  import dcache_pkg::*;

  logic [`DCACHE_OFS_WIDTH-3:0] word_sel;
  logic [1:0]                   byte_sel;
  logic [31:0]                  word;
  logic [7:0]                   byte_v;
  logic [15:0]                  half_v;

  assign word_sel = offset_i[`DCACHE_OFS_WIDTH-1:2];
  assign byte_sel = offset_i[1:0];

  // ====================
  // store merge
  // ====================
  always_comb begin
    store_line_o = line_i;
    case (size_i)
      SIZE_B, SIZE_BU: store_line_o[word_sel][{byte_sel, 3'b000} +: 8] = wdata_i[7:0];
      SIZE_H, SIZE_HU: store_line_o[word_sel][{byte_sel[1], 4'b0000} +: 16] = wdata_i[15:0];
      default:         store_line_o[word_sel] = wdata_i;
    endcase
  end

  // ====================
  // load extract
  // ====================
  always_comb begin
    word   = line_i[word_sel];
    byte_v = word[{byte_sel, 3'b000} +: 8];
    // halfwords are aligned, only bit 1 picks the half
    half_v = word[{byte_sel[1], 4'b0000} +: 16];
    case (size_i)
      SIZE_B:  load_data_o = {{24{byte_v[7]}}, byte_v};
      SIZE_BU: load_data_o = {24'b0, byte_v};
      SIZE_H:  load_data_o = {{16{half_v[15]}}, half_v};
      SIZE_HU: load_data_o = {16'b0, half_v};
      default: load_data_o = word;
    endcase
  end

endmodule

// ==== source/dcache_miss_fsm.sv ====
`timescale 1ns/1ps
`include "dcache_macros.svh"

/*
 * miss engine
 * writes back a dirty victim as a write burst, then refills the line by a read burst
 */
module dcache_miss_fsm (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   miss_start_i,
  input  dcache_pkg::miss_ctx_t  miss_ctx_i,
  output dcache_pkg::axi_ar_t    ar_o,
  input  logic                   ar_ready_i,
  output dcache_pkg::axi_aw_t    aw_o,
  input  logic                   aw_ready_i,
  output dcache_pkg::axi_w_t     w_o,
  input  logic                   w_ready_i,
  input  dcache_pkg::axi_r_t     r_i,
  output logic                   r_ready_o,
  output logic                   miss_busy_o,
  output logic                   refill_done_o,
  output dcache_pkg::line_t      refill_line_o
);
  import dcache_pkg::*;

  localparam int BEAT_W = $clog2(`DCACHE_WORDS);

  typedef enum logic [1:0] {
    S_IDLE,
    S_MISS,
    S_REPLACE,
    S_REFILL
  } state_e;

  state_e            state;
  state_e            state_nxt;
  miss_ctx_t         ctx_q;
  line_t             refill_buf;
  logic [BEAT_W-1:0] w_idx;
  logic [BEAT_W-1:0] r_idx;
  logic              wb_done;
  logic              aw_fire;
  logic              w_fire;
  logic              ar_fire;
  logic              r_fire;

  // ====================
  // bus channels
  // ====================
  always_comb begin
    aw_o.valid = state == S_MISS && ctx_q.victim_dirty;
    aw_o.addr  = ctx_q.victim_addr;
    aw_o.len   = 8'(`DCACHE_BURST_LEN);

    w_o.valid = state == S_REPLACE && !wb_done;
    w_o.data  = ctx_q.victim_line[w_idx];
    w_o.last  = w_idx == BEAT_W'(`DCACHE_WORDS - 1);

    // clean victim goes straight to the read, else after the last w beat
    ar_o.valid = (state == S_MISS && !ctx_q.victim_dirty) || (state == S_REPLACE && wb_done);
    ar_o.addr  = ctx_q.line_addr;
    ar_o.len   = 8'(`DCACHE_BURST_LEN);

    r_ready_o = state == S_REFILL;

    aw_fire = aw_o.valid && aw_ready_i;
    w_fire  = w_o.valid && w_ready_i;
    ar_fire = ar_o.valid && ar_ready_i;
    r_fire  = r_i.valid && r_ready_o;
  end

  assign miss_busy_o   = state != S_IDLE;
  assign refill_done_o = r_fire && r_i.last;

  // last beat goes straight into the line, no wait for the buffer
  always_comb begin
    refill_line_o        = refill_buf;
    refill_line_o[r_idx] = r_i.data;
  end

  always_comb begin
    state_nxt = state;
    case (state)
      S_IDLE: begin
        if (miss_start_i) begin
          state_nxt = S_MISS;
        end
      end
      S_MISS: begin
        if (aw_fire) begin
          state_nxt = S_REPLACE;
        end else if (ar_fire) begin
          state_nxt = S_REFILL;
        end
      end
      S_REPLACE: begin
        if (ar_fire) begin
          state_nxt = S_REFILL;
        end
      end
      S_REFILL: begin
        if (refill_done_o) begin
          state_nxt = S_IDLE;
        end
      end
      default: state_nxt = S_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= S_IDLE;
      w_idx   <= '0;
      r_idx   <= '0;
      wb_done <= 1'b0;
    end else begin
      state <= state_nxt;
      if (state == S_MISS) begin
        w_idx   <= '0;
        r_idx   <= '0;
        wb_done <= 1'b0;
      end
      if (w_fire) begin
        w_idx <= w_idx + 1'b1;
        if (w_o.last) begin
          wb_done <= 1'b1;
        end
      end
      if (r_fire) begin
        r_idx <= r_idx + 1'b1;
      end
    end
  end

  // miss context and refill data
  always_ff @(posedge clk) begin
    if (miss_start_i && state == S_IDLE) begin
      ctx_q <= miss_ctx_i;
    end
    if (r_fire) begin
      refill_buf[r_idx] <= r_i.data;
    end
  end

endmodule

// ==== source/dcache_pipe.sv ====
`timescale 1ns/1ps
`include "dcache_macros.svh"

/*
 * cache pipeline
 * stage 0 array read, stage 1 tag compare and LRU, stage 2 response and array writes
 */
module dcache_pipe (
  input  logic                     clk,
  input  logic                     rst_n,
  input  dcache_pkg::dcache_req_t  req_i,
  output logic                     req_ready_o,
  output dcache_pkg::dcache_rsp_t  rsp_o,
  input  logic                     rsp_ready_i,
  output logic                     miss_start_o,
  output dcache_pkg::miss_ctx_t    miss_ctx_o,
  input  logic                     miss_busy_i,
  input  logic                     refill_done_i,
  input  dcache_pkg::line_t        refill_line_i
);
  import dcache_pkg::*;

  localparam int WAYS = `DCACHE_WAY_NUM;
  localparam int SETS = 1 << `DCACHE_IDX_WIDTH;

  typedef logic [$clog2(WAYS)-1:0] way_t;

  logic                 s1_ready;
  logic                 s2_ready;
  dcache_req_t          s1_req;
  dcache_req_t          s2_req;
  logic                 s2_miss;
  way_t                 s2_way;
  meta_t                s2_vmeta;
  tag_t                 s2_vtag;

  // array ports
  logic [WAYS-1:0]      tag_we;
  logic [WAYS-1:0]      meta_we;
  logic [WAYS-1:0]      data_we;
  idx_t                 wr_idx;
  idx_t                 tag_raddr;
  idx_t                 data_raddr;
  tag_t                 tag_wdata;
  meta_t                meta_wdata;
  line_t                data_wdata;
  tag_t  [WAYS-1:0]     tag_rdata;
  meta_t [WAYS-1:0]     meta_rdata;
  line_t [WAYS-1:0]     data_rdata;
  logic                 lru_we;
  logic                 lru_wdata;
  logic                 lru_rdata;

  // stage 1 compare
  tag_t  [WAYS-1:0]     s1_tag;
  meta_t [WAYS-1:0]     s1_meta;
  logic  [WAYS-1:0]     hit_oh;
  logic                 s1_hit;
  way_t                 hit_way;
  way_t                 s1_way;

  // stage 2 datapath
  line_t                s2_line;
  line_t                lane_line;
  line_t                store_line;
  logic [31:0]          load_data;
  logic                 s2_store;
  logic                 hit_store;

  // ====================
  // handshake
  // ====================
  assign s2_ready    = !s2_req.valid || (rsp_o.valid && rsp_ready_i);
  assign s1_ready    = !s1_req.valid || s2_ready;
  assign req_ready_o = s1_ready;

  // stalled stages keep re-reading their own set
  assign tag_raddr  = s1_ready ? `DCACHE_IDX_OF(req_i.addr) : `DCACHE_IDX_OF(s1_req.addr);
  assign data_raddr = s2_ready ? `DCACHE_IDX_OF(s1_req.addr) : `DCACHE_IDX_OF(s2_req.addr);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_req  <= '0;
      s2_req  <= '0;
      s2_miss <= 1'b0;
    end else begin
      if (s1_ready) begin
        s1_req <= req_i;
      end
      if (s2_ready) begin
        s2_req  <= s1_req;
        s2_miss <= s1_req.valid && !s1_hit;
      end else if (refill_done_i) begin
        s2_miss <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (s2_ready) begin
      s2_way   <= s1_way;
      s2_vmeta <= s1_meta[s1_way];
      s2_vtag  <= s1_tag[s1_way];
    end
  end

  // ====================
  // stage 1
  // ====================
  always_comb begin
    for (int w = 0; w < WAYS; w++) begin
      // forward a same-set write from stage 2
      s1_tag[w]  = (tag_we[w] && wr_idx == `DCACHE_IDX_OF(s1_req.addr)) ?
                   tag_wdata : tag_rdata[w];
      s1_meta[w] = (meta_we[w] && wr_idx == `DCACHE_IDX_OF(s1_req.addr)) ?
                   meta_wdata : meta_rdata[w];
      hit_oh[w]  = s1_meta[w].valid && s1_tag[w] == `DCACHE_TAG_OF(s1_req.addr);
    end
    hit_way = '0;
    for (int w = 0; w < WAYS; w++) begin
      if (hit_oh[w]) begin
        hit_way = way_t'(w);
      end
    end
    s1_hit = |hit_oh;
    // lru bit names the way to evict
    s1_way = s1_hit ? hit_way : lru_rdata;
  end

  assign lru_we    = s1_req.valid && s2_ready;
  assign lru_wdata = ~s1_way;

  // ====================
  // stage 2
  // ====================
  always_comb begin
    s2_line   = data_rdata[s2_way];
    lane_line = refill_done_i ? refill_line_i : s2_line;
    s2_store  = s2_req.mem_op == MEM_STORE;
    hit_store = s2_req.valid && !s2_miss && s2_store;

    wr_idx     = `DCACHE_IDX_OF(s2_req.addr);
    tag_wdata  = `DCACHE_TAG_OF(s2_req.addr);
    meta_wdata = '{valid: 1'b1, dirty: s2_store};
    data_wdata = s2_store ? store_line : lane_line;
    tag_we     = '0;
    meta_we    = '0;
    data_we    = '0;
    if (refill_done_i) begin
      tag_we[s2_way]  = 1'b1;
      meta_we[s2_way] = 1'b1;
      data_we[s2_way] = 1'b1;
    end else if (hit_store) begin
      meta_we[s2_way] = 1'b1;
      data_we[s2_way] = 1'b1;
    end

    rsp_o.valid  = s2_req.valid && !s2_miss && !miss_busy_i;
    rsp_o.mem_op = s2_req.mem_op;
    rsp_o.rdata  = s2_store ? 32'b0 : load_data;

    miss_start_o            = s2_req.valid && s2_miss && !miss_busy_i;
    miss_ctx_o.line_addr    = `DCACHE_LINE_ALIGN(s2_req.addr);
    miss_ctx_o.victim_addr  = {s2_vtag, wr_idx, {`DCACHE_OFS_WIDTH{1'b0}}};
    miss_ctx_o.victim_dirty = s2_vmeta.valid && s2_vmeta.dirty;
    miss_ctx_o.victim_line  = s2_line;
  end

  dcache_byte_lane u_lane (
    .size_i       (s2_req.size_op),
    .offset_i     (`DCACHE_OFS_OF(s2_req.addr)),
    .line_i       (lane_line),
    .wdata_i      (s2_req.wdata),
    .store_line_o (store_line),
    .load_data_o  (load_data)
  );

  // ====================
  // arrays
  // ====================
  for (genvar w = 0; w < WAYS; w++) begin : gen_way
    dcache_sram #(.payload_t(tag_t), .DEPTH(SETS)) u_tag (
      .clk(clk), .rst_n(rst_n), .we_i(tag_we[w]), .waddr_i(wr_idx),
      .wdata_i(tag_wdata), .raddr_i(tag_raddr), .rdata_o(tag_rdata[w])
    );
    dcache_sram #(.payload_t(meta_t), .DEPTH(SETS)) u_meta (
      .clk(clk), .rst_n(rst_n), .we_i(meta_we[w]), .waddr_i(wr_idx),
      .wdata_i(meta_wdata), .raddr_i(tag_raddr), .rdata_o(meta_rdata[w])
    );
    dcache_sram #(.payload_t(line_t), .DEPTH(SETS)) u_data (
      .clk(clk), .rst_n(rst_n), .we_i(data_we[w]), .waddr_i(wr_idx),
      .wdata_i(data_wdata), .raddr_i(data_raddr), .rdata_o(data_rdata[w])
    );
  end

  dcache_sram #(.payload_t(logic), .DEPTH(SETS)) u_lru (
    .clk     (clk),
    .rst_n   (rst_n),
    .we_i    (lru_we),
    .waddr_i (`DCACHE_IDX_OF(s1_req.addr)),
    .wdata_i (lru_wdata),
    .raddr_i (tag_raddr),
    .rdata_o (lru_rdata)
  );

endmodule

// ==== source/dcache_top.sv ====
`timescale 1ns/1ps

/*
 * write-back data cache top level
 * three-stage pipeline plus miss engine on an AXI-style bus
 */
module dcache_top (
  input  logic                     clk,
  input  logic                     rst_n,
  input  dcache_pkg::dcache_req_t  req_i,
  output logic                     req_ready_o,
  output dcache_pkg::dcache_rsp_t  rsp_o,
  input  logic                     rsp_ready_i,
  output dcache_pkg::axi_ar_t      ar_o,
  input  logic                     ar_ready_i,
  output dcache_pkg::axi_aw_t      aw_o,
  input  logic                     aw_ready_i,
  output dcache_pkg::axi_w_t       w_o,
  input  logic                     w_ready_i,
  input  dcache_pkg::axi_r_t       r_i,
  output logic                     r_ready_o
);
  import dcache_pkg::*;

  logic      miss_start;
  logic      miss_busy;
  logic      refill_done;
  miss_ctx_t miss_ctx;
  line_t     refill_line;

  dcache_pipe u_pipe (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_i         (req_i),
    .req_ready_o   (req_ready_o),
    .rsp_o         (rsp_o),
    .rsp_ready_i   (rsp_ready_i),
    .miss_start_o  (miss_start),
    .miss_ctx_o    (miss_ctx),
    .miss_busy_i   (miss_busy),
    .refill_done_i (refill_done),
    .refill_line_i (refill_line)
  );

  dcache_miss_fsm u_miss (
    .clk           (clk),
    .rst_n         (rst_n),
    .miss_start_i  (miss_start),
    .miss_ctx_i    (miss_ctx),
    .ar_o          (ar_o),
    .ar_ready_i    (ar_ready_i),
    .aw_o          (aw_o),
    .aw_ready_i    (aw_ready_i),
    .w_o           (w_o),
    .w_ready_i     (w_ready_i),
    .r_i           (r_i),
    .r_ready_o     (r_ready_o),
    .miss_busy_o   (miss_busy),
    .refill_done_o (refill_done),
    .refill_line_o (refill_line)
  );

endmodule

// ==== dv/dcache_props.sv ====
`timescale 1ns/1ps
`include "dcache_macros.svh"

/*
 * bus and response protocol checks
 * bound into the cache top level
 */
module dcache_props (
  input  logic                    clk,
  input  logic                    rst_n,
  input  dcache_pkg::dcache_rsp_t rsp_o,
  input  logic                    rsp_ready_i,
  input  dcache_pkg::axi_ar_t     ar_o,
  input  dcache_pkg::axi_aw_t     aw_o,
  input  dcache_pkg::axi_w_t      w_o,
  input  logic                    w_ready_i,
  input  logic                    r_ready_o
);
  import dcache_pkg::*;

  localparam int BEAT_W = $clog2(`DCACHE_WORDS);

  int unsigned       fail_cnt;
  logic [3:0]        quiet_cnt;
  logic [BEAT_W-1:0] w_beat;

  initial begin
    fail_cnt = 0;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      quiet_cnt <= 4'd0;
      w_beat    <= '0;
    end else begin
      if (quiet_cnt != 4'd10) begin
        quiet_cnt <= quiet_cnt + 4'd1;
      end
      // wraps back to zero after a full burst
      if (w_o.valid && w_ready_i) begin
        w_beat <= w_beat + 1'b1;
      end
    end
  end

  // ====================
  // checks
  // ====================
  reset_quiet: assert property (@(posedge clk)
    rst_n && quiet_cnt < 4'd10 |->
      !rsp_o.valid && !ar_o.valid && !aw_o.valid && !w_o.valid && !r_ready_o)
    else begin
      $error("bus or response active in the cycles after reset");
      fail_cnt++;
    end

  aw_shape: assert property (@(posedge clk) disable iff (!rst_n)
    aw_o.valid |-> aw_o.addr[`DCACHE_OFS_WIDTH-1:0] == '0 && aw_o.len == 8'(`DCACHE_BURST_LEN))
    else begin
      $error("aw address not line aligned or wrong burst length");
      fail_cnt++;
    end

  ar_shape: assert property (@(posedge clk) disable iff (!rst_n)
    ar_o.valid |-> ar_o.addr[`DCACHE_OFS_WIDTH-1:0] == '0 && ar_o.len == 8'(`DCACHE_BURST_LEN))
    else begin
      $error("ar address not line aligned or wrong burst length");
      fail_cnt++;
    end

  // last only on the final beat of the burst
  w_last: assert property (@(posedge clk) disable iff (!rst_n)
    w_o.valid |-> w_o.last == (w_beat == BEAT_W'(`DCACHE_WORDS - 1)))
    else begin
      $error("w last does not mark the final beat");
      fail_cnt++;
    end

  rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_o.valid && !rsp_ready_i |=> rsp_o.valid && $stable(rsp_o))
    else begin
      $error("response changed while stalled");
      fail_cnt++;
    end

endmodule

bind dcache_top dcache_props u_props (
  .clk         (clk),
  .rst_n       (rst_n),
  .rsp_o       (rsp_o),
  .rsp_ready_i (rsp_ready_i),
  .ar_o        (ar_o),
  .aw_o        (aw_o),
  .w_o         (w_o),
  .w_ready_i   (w_ready_i),
  .r_ready_o   (r_ready_o)
);

// ==== dv/dcache_tb.sv ====
`timescale 1ns/1ps
`include "dcache_macros.svh"

/*
 * data cache testbench
 * bus slave over a shadow memory, processor stimulus and response checks
 */
module dcache_tb;
  import dcache_pkg::*;

  localparam int TIMEOUT = 4000;

  typedef struct packed {
    mem_op_e     op;
    logic [31:0] addr;
    logic [31:0] data;
    logic        fast;
    logic [31:0] acc_cyc;
  } expect_t;

  logic        clk;
  logic        rst_n;
  dcache_req_t req_i;
  logic        req_ready_o;
  dcache_rsp_t rsp_o;
  logic        rsp_ready_i;
  axi_ar_t     ar_o;
  logic        ar_ready_i;
  axi_aw_t     aw_o;
  logic        aw_ready_i;
  axi_w_t      w_o;
  logic        w_ready_i;
  axi_r_t      r_i;
  logic        r_ready_o;

  logic [31:0] shadow [logic [29:0]];
  expect_t     exp_q [$];
  logic [31:0] aw_log [$];
  expect_t     got;
  logic [15:0] lfsr;
  logic [31:0] cyc;
  logic [31:0] rd_addr;
  logic [31:0] wr_addr;
  logic        rd_active;
  int          rd_beat;
  int          wr_beat;
  int          ar_cnt;
  int          w_cnt;
  int          errors;
  int          tests;
  int          tests_failed;
  int          fails_at_start;

  dcache_top uut (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_i       (req_i),
    .req_ready_o (req_ready_o),
    .rsp_o       (rsp_o),
    .rsp_ready_i (rsp_ready_i),
    .ar_o        (ar_o),
    .ar_ready_i  (ar_ready_i),
    .aw_o        (aw_o),
    .aw_ready_i  (aw_ready_i),
    .w_o         (w_o),
    .w_ready_i   (w_ready_i),
    .r_i         (r_i),
    .r_ready_o   (r_ready_o)
  );

  initial begin
    clk = 1'b0;
  end

  always #2 clk = ~clk;

  // ====================
  // memory model
  // ====================
  function automatic logic [31:0] fill_word(input logic [31:0] a);
    return {a[7:0], a[15:8], a[23:16], a[31:24]} ^ (a << 3) ^ 32'hC3A5_5A3C;
  endfunction

  function automatic logic [31:0] mem_rd(input logic [31:0] a);
    if (shadow.exists(a[31:2])) begin
      return shadow[a[31:2]];
    end
    return fill_word({a[31:2], 2'b00});
  endfunction

  function automatic void mem_wr(input logic [31:0] a, input logic [31:0] d);
    shadow[a[31:2]] = d;
  endfunction

  // x^16 + x^14 + x^13 + x^11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic take_bit();
    lfsr = lfsr_next(lfsr);
    return lfsr[0];
  endfunction

  // expected load value, shift the addressed bytes down then extend
  function automatic logic [31:0] load_value(input logic [31:0] word, input logic [1:0] ofs,
                                             input size_op_e sz);
    logic [31:0] sh;
    sh = word >> (8 * ofs);
    case (sz)
      SIZE_B:  return {{24{sh[7]}}, sh[7:0]};
      SIZE_BU: return {24'b0, sh[7:0]};
      SIZE_H:  return {{16{sh[15]}}, sh[15:0]};
      SIZE_HU: return {16'b0, sh[15:0]};
      default: return word;
    endcase
  endfunction

  function automatic logic [31:0] store_merge(input logic [31:0] old, input logic [31:0] d,
                                              input logic [1:0] ofs, input size_op_e sz);
    logic [31:0] mask;
    case (sz)
      SIZE_B, SIZE_BU: mask = 32'h0000_00FF;
      SIZE_H, SIZE_HU: mask = 32'h0000_FFFF;
      default:         mask = 32'hFFFF_FFFF;
    endcase
    mask = mask << (8 * ofs);
    return (old & ~mask) | ((d << (8 * ofs)) & mask);
  endfunction

  function automatic int total_fails();
    return errors + int'(uut.u_props.fail_cnt);
  endfunction

  // bus slave, readies follow the LFSR
  always @(posedge clk) begin
    if (ar_o.valid && ar_ready_i) begin
      // the read burst fetches the line of the missing request
      if (exp_q.size() == 0) begin
        $display("read burst at %0t with no request outstanding", $time);
        errors++;
      end else begin
        assert (ar_o.addr == {exp_q[0].addr[31:4], 4'b0000}) else begin
          $display("Error: %0t ar_o.addr got %h expected %h", $time, ar_o.addr,
                   {exp_q[0].addr[31:4], 4'b0000});
          errors++;
        end
      end
      rd_active = 1'b1;
      rd_addr   = ar_o.addr;
      rd_beat   = 0;
      ar_cnt++;
    end else if (r_i.valid && r_ready_o) begin
      rd_beat++;
      rd_active = rd_beat < `DCACHE_WORDS;
    end
    if (aw_o.valid && aw_ready_i) begin
      wr_addr = aw_o.addr;
      wr_beat = 0;
      aw_log.push_back(aw_o.addr);
    end
    if (w_o.valid && w_ready_i) begin
      assert (w_o.data == mem_rd(wr_addr + 32'(4 * wr_beat))) else begin
        $display("Error: %0t w_o.data got %h expected %h", $time, w_o.data,
                 mem_rd(wr_addr + 32'(4 * wr_beat)));
        errors++;
      end
      mem_wr(wr_addr + 32'(4 * wr_beat), w_o.data);
      wr_beat++;
      w_cnt++;
    end
    ar_ready_i <= take_bit();
    aw_ready_i <= take_bit();
    w_ready_i  <= take_bit();
    // an offered beat stays until taken
    if (rd_active && ((r_i.valid && !r_ready_o) || take_bit())) begin
      r_i <= '{valid: 1'b1, data: mem_rd(rd_addr + 32'(4 * rd_beat)),
               last: rd_beat == `DCACHE_WORDS - 1};
    end else begin
      r_i.valid <= 1'b0;
    end
  end

  // response checks against the expectation queue
  always @(posedge clk) begin
    cyc <= cyc + 32'd1;
    if (rst_n && rsp_o.valid && rsp_ready_i) begin
      if (exp_q.size() == 0) begin
        $display("response at %0t with no request outstanding", $time);
        errors++;
      end else begin
        got = exp_q.pop_front();
        assert (rsp_o.mem_op == got.op) else begin
          $display("Error: %0t rsp_o.mem_op got %0d expected %0d", $time, rsp_o.mem_op, got.op);
          errors++;
        end
        if (got.op == MEM_LOAD) begin
          assert (rsp_o.rdata == got.data) else begin
            $display("Error: %0t rsp_o.rdata got %h expected %h", $time, rsp_o.rdata, got.data);
            errors++;
          end
        end
        if (got.fast) begin
          assert (cyc - got.acc_cyc == 32'd2) else begin
            $display("Error: %0t hit latency got %0d expected 2", $time, cyc - got.acc_cyc);
            errors++;
          end
        end
      end
    end
  end

  // ====================
  // run control
  // ====================
  task automatic end_run();
    $display("tests run %0d, tests failed %0d, failed checks %0d", tests, tests_failed,
             total_fails());
    if (total_fails() == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  endtask

  task automatic fail_timeout(input string what);
    $display("timeout at %0t while waiting for %s", $time, what);
    errors++;
    end_run();
  endtask

  task automatic report_test(input string name);
    int f;
    f = total_fails() - fails_at_start;
    tests++;
    if (f == 0) begin
      $display("test %0d %s: ok", tests, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d failed checks", tests, name, f);
    end
    fails_at_start = total_fails();
  endtask

  task automatic send_req(input logic [31:0] a, input mem_op_e op, input size_op_e sz,
                          input logic [31:0] d, input logic fast);
    expect_t e;
    int      n;
    e.op   = op;
    e.addr = a;
    e.fast = fast;
    e.data = 32'b0;
    if (op == MEM_STORE) begin
      mem_wr(a, store_merge(mem_rd(a), d, a[1:0], sz));
    end else begin
      e.data = load_value(mem_rd(a), a[1:0], sz);
    end
    req_i <= '{valid: 1'b1, addr: a, mem_op: op, size_op: sz, wdata: d};
    n = 0;
    @(posedge clk);
    while (!req_ready_o) begin
      n++;
      if (n > TIMEOUT) begin
        fail_timeout("request acceptance");
      end
      @(posedge clk);
    end
    e.acc_cyc = cyc;
    exp_q.push_back(e);
  endtask

  task automatic release_req();
    req_i.valid <= 1'b0;
  endtask

  task automatic drain();
    int n;
    n = 0;
    while (exp_q.size() != 0) begin
      @(posedge clk);
      n++;
      if (n > TIMEOUT) begin
        fail_timeout("outstanding responses");
      end
    end
  endtask

  task automatic do_access(input logic [31:0] a, input mem_op_e op, input size_op_e sz,
                           input logic [31:0] d, input logic fast);
    send_req(a, op, sz, d, fast);
    release_req();
    drain();
  endtask

  // ====================
  // stimulus
  // ====================
  initial begin
    logic [3:0]  miss_ofs [5];
    logic [31:0] a;
    int          n;
    rst_n = 1'b0;
    req_i = '0;
    rsp_ready_i = 1'b0;
    ar_ready_i = 1'b0;
    aw_ready_i = 1'b0;
    w_ready_i = 1'b0;
    r_i = '0;
    lfsr = 16'd17565;
    cyc = '0;
    rd_active = 1'b0;
    rd_addr = '0;
    wr_addr = '0;
    rd_beat = 0;
    wr_beat = 0;
    ar_cnt = 0;
    w_cnt = 0;
    errors = 0;
    tests = 0;
    tests_failed = 0;
    fails_at_start = 0;
    // offsets aligned for B, H, W, BU, HU
    miss_ofs = '{4'd3, 4'd2, 4'd4, 4'd7, 4'd14};
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    rsp_ready_i <= 1'b1;

    repeat (10) @(posedge clk);
    report_test("reset quiet");

    // one fresh set per size, miss first then hit in the same line
    for (int k = 0; k < 5; k++) begin
      a = 32'h0000_2000 + 32'(k * 16) + 32'(miss_ofs[k]);
      do_access(a, MEM_LOAD, size_op_e'(k), 32'b0, 1'b0);
      do_access(a ^ 32'h8, MEM_LOAD, size_op_e'(k), 32'b0, 1'b1);
    end
    report_test("load sizes");

    do_access(32'h0000_2011, MEM_STORE, SIZE_B, 32'h0000_00A7, 1'b1);
    do_access(32'h0000_2010, MEM_LOAD, SIZE_W, 32'b0, 1'b1);
    do_access(32'h0000_2016, MEM_STORE, SIZE_H, 32'h1234_BEEF, 1'b1);
    do_access(32'h0000_2016, MEM_LOAD, SIZE_HU, 32'b0, 1'b1);
    do_access(32'h0000_2014, MEM_LOAD, SIZE_W, 32'b0, 1'b1);
    do_access(32'h0000_2018, MEM_STORE, SIZE_W, 32'hCAFE_F00D, 1'b1);
    do_access(32'h0000_201B, MEM_LOAD, SIZE_B, 32'b0, 1'b1);
    // store into a line that is not cached yet
    do_access(32'h0000_3052, MEM_STORE, SIZE_H, 32'h0000_8001, 1'b0);
    do_access(32'h0000_3050, MEM_LOAD, SIZE_W, 32'b0, 1'b1);
    report_test("store merge");

    // three lines in set 9, the dirty first one is the LRU victim
    aw_log.delete();
    w_cnt = 0;
    do_access(32'h0000_4090, MEM_STORE, SIZE_W, 32'h5EED_0001, 1'b0);
    do_access(32'h0000_5094, MEM_LOAD, SIZE_W, 32'b0, 1'b0);
    do_access(32'h0000_6098, MEM_LOAD, SIZE_W, 32'b0, 1'b0);
    do_access(32'h0000_4090, MEM_LOAD, SIZE_W, 32'b0, 1'b0);
    assert (aw_log.size() == 1) else begin
      $display("Error: %0t aw_o burst count got %0d expected 1", $time, aw_log.size());
      errors++;
    end
    if (aw_log.size() != 0) begin
      assert (aw_log[0] == 32'h0000_4090) else begin
        $display("Error: %0t aw_o.addr got %h expected %h", $time, aw_log[0], 32'h0000_4090);
        errors++;
      end
    end
    assert (w_cnt == `DCACHE_WORDS) else begin
      $display("Error: %0t w_o beats got %0d expected %0d", $time, w_cnt, `DCACHE_WORDS);
      errors++;
    end
    report_test("write-back");

    // five load misses, one store miss, four misses in set 9
    assert (ar_cnt == 10) else begin
      $display("Error: %0t ar_o bursts got %0d expected 10", $time, ar_cnt);
      errors++;
    end
    report_test("refill bursts");

    rsp_ready_i <= 1'b0;
    send_req(32'h0000_2004, MEM_LOAD, SIZE_W, 32'b0, 1'b0);
    release_req();
    n = 0;
    while (!rsp_o.valid) begin
      @(posedge clk);
      n++;
      if (n > TIMEOUT) begin
        fail_timeout("stalled response");
      end
    end
    repeat (6) @(posedge clk);
    rsp_ready_i <= 1'b1;
    drain();
    // back to back hits over the cached lines
    for (int k = 0; k < 8; k++) begin
      send_req(32'h0000_2000 + 32'((k % 5) * 16) + 32'((k / 5) * 4), MEM_LOAD,
               (k % 2 == 0) ? SIZE_W : SIZE_B, 32'b0, 1'b1);
    end
    release_req();
    drain();
    report_test("back-pressure and hit latency");

    end_run();
  end

endmodule

// ==== list.f ====
+incdir+source
source/dcache_pkg.sv
source/dcache_sram.sv
source/dcache_byte_lane.sv
source/dcache_miss_fsm.sv
source/dcache_pipe.sv
source/dcache_top.sv
dv/dcache_props.sv
dv/dcache_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the data cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module dcache_tb -f list.f; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/Vdcache_tb +verilator+error+limit+1000)
status=$?
printf '%s\n' "$out"

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -q "All tests passed"; then
  exit 0
fi
echo "pass message not found"
exit 1
